//--- source/bus_pkg.sv
package bus_pkg;

    // Bus widths
    localparam int addr_width = 32;
    localparam int data_width = 32;
    localparam int strb_width = data_width / 8;

    // AXI response codes
    typedef enum logic [1:0] {
        okay   = 2'b00,
        slverr = 2'b10,
        decerr = 2'b11
    } resp_e;

    // Bridge sequencing through an APB transfer
    typedef enum logic [1:0] {
        idle,
        setup,
        access
    } apb_phase_e;

endpackage

//--- source/map_pkg.sv
package map_pkg;

    // Two APB windows behind the bridge
    localparam int periph_count = 2;
    localparam logic [periph_count-1:0][31:0] periph_base = {
        32'h0000_2000,
        32'h0000_1000
    };
    localparam logic [31:0] periph_size = 32'h100;

    // Offsets of reg_count * 4 and above are unmapped
    localparam int reg_count = 8;

    localparam int pause_max_trans = 1;

endpackage

//--- source/axil_if.sv
`timescale 1ns/1ps

interface axil_if import bus_pkg::*; ();

    logic                  awvalid;
    logic                  awready;
    logic [addr_width-1:0] awaddr;
    logic [2:0]            awprot;

    logic                  wvalid;
    logic                  wready;
    logic [data_width-1:0] wdata;
    logic [strb_width-1:0] wstrb;

    logic                  bvalid;
    logic                  bready;
    resp_e                 bresp;

    logic                  arvalid;
    logic                  arready;
    logic [addr_width-1:0] araddr;
    logic [2:0]            arprot;

    logic                  rvalid;
    logic                  rready;
    logic [data_width-1:0] rdata;
    resp_e                 rresp;

    modport manager (
        output awvalid, awaddr, awprot, wvalid, wdata, wstrb, bready,
        output arvalid, araddr, arprot, rready,
        input  awready, wready, bvalid, bresp, arready, rvalid, rdata, rresp
    );

    modport subordinate (
        input  awvalid, awaddr, awprot, wvalid, wdata, wstrb, bready,
        input  arvalid, araddr, arprot, rready,
        output awready, wready, bvalid, bresp, arready, rvalid, rdata, rresp
    );

endinterface

//--- source/apb_if.sv
`timescale 1ns/1ps

interface apb_if import bus_pkg::*; ();

    logic [addr_width-1:0] paddr;
    logic [2:0]            pprot;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [data_width-1:0] pwdata;
    logic [strb_width-1:0] pstrb;
    logic                  pready;
    logic [data_width-1:0] prdata;
    logic                  pslverr;

    modport requester (
        output paddr, pprot, psel, penable, pwrite, pwdata, pstrb,
        input  pready, prdata, pslverr
    );

    modport completer (
        input  paddr, pprot, psel, penable, pwrite, pwdata, pstrb,
        output pready, prdata, pslverr
    );

endinterface

//--- source/axil_pause.sv
`timescale 1ns/1ps

module axil_pause import map_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        pause_req,
    output logic        pause_ack,
    axil_if.subordinate slv,
    axil_if.manager     mst
);

    logic [1:0] cnt;
    logic       gate_open;
    logic       aw_hs;
    logic       ar_hs;
    logic       b_hs;
    logic       r_hs;

    // New requests only while not paused and below the outstanding limit
    assign gate_open = !pause_req && (cnt < pause_max_trans);

    assign mst.awvalid = slv.awvalid && gate_open;
    assign slv.awready = mst.awready && gate_open;
    assign mst.awaddr  = slv.awaddr;
    assign mst.awprot  = slv.awprot;

    assign mst.wvalid  = slv.wvalid;
    assign slv.wready  = mst.wready;
    assign mst.wdata   = slv.wdata;
    assign mst.wstrb   = slv.wstrb;

    assign slv.bvalid  = mst.bvalid;
    assign mst.bready  = slv.bready;
    assign slv.bresp   = mst.bresp;

    assign mst.arvalid = slv.arvalid && gate_open;
    assign slv.arready = mst.arready && gate_open;
    assign mst.araddr  = slv.araddr;
    assign mst.arprot  = slv.arprot;

    assign slv.rvalid  = mst.rvalid;
    assign mst.rready  = slv.rready;
    assign slv.rdata   = mst.rdata;
    assign slv.rresp   = mst.rresp;

    assign aw_hs = mst.awvalid && mst.awready;
    assign ar_hs = mst.arvalid && mst.arready;
    assign b_hs  = mst.bvalid && mst.bready;
    assign r_hs  = mst.rvalid && mst.rready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt       <= '0;
            pause_ack <= 1'b0;
        end else begin
            cnt       <= cnt + {1'b0, aw_hs} + {1'b0, ar_hs} - {1'b0, b_hs} - {1'b0, r_hs};
            // Acknowledge once drained
            pause_ack <= pause_req && (cnt == '0);
        end
    end

endmodule

//--- source/axil_apb_bridge.sv
`timescale 1ns/1ps

module axil_apb_bridge import bus_pkg::*; import map_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    axil_if.subordinate slv,
    apb_if.requester    apb0,
    apb_if.requester    apb1
);

    apb_phase_e state;

    // Captured request
    logic [addr_width-1:0] req_addr;
    logic [data_width-1:0] req_wdata;
    logic [strb_width-1:0] req_strb;
    logic [2:0]            req_prot;
    logic                  req_write;
    logic                  req_idx;
    logic                  last_wr;

    // Response holding registers
    logic                  bvalid_q;
    resp_e                 bresp_q;
    logic                  rvalid_q;
    resp_e                 rresp_q;
    logic [data_width-1:0] rdata_q;

    logic                  free;
    logic                  wr_req;
    logic                  rd_req;
    logic                  grant_wr;
    logic                  grant_rd;
    logic                  take;
    logic [addr_width-1:0] in_addr;
    logic                  hit;
    logic                  hit_idx;
    logic [addr_width-1:0] rebased;
    logic                  psel0;
    logic                  psel1;
    logic                  sel_pready;
    logic                  sel_pslverr;
    logic [data_width-1:0] sel_prdata;

    // ************************************************************************
    // Arbitration and decode
    // ************************************************************************

    assign free   = (state == idle) && !bvalid_q && !rvalid_q;
    assign wr_req = slv.awvalid && slv.wvalid;
    assign rd_req = slv.arvalid;

    // Write wins unless it was served last
    assign grant_wr = free && wr_req && (!rd_req || !last_wr);
    assign grant_rd = free && rd_req && !grant_wr;
    assign take     = grant_wr || grant_rd;
    assign in_addr  = grant_wr ? slv.awaddr : slv.araddr;

    always_comb begin
        hit     = 1'b0;
        hit_idx = 1'b0;
        rebased = '0;
        for (int i = 0; i < periph_count; i++) begin
            // Wraps to a large value below the base
            if (in_addr - periph_base[i] < periph_size) begin
                hit     = 1'b1;
                hit_idx = 1'(i);
                rebased = in_addr - periph_base[i];
            end
        end
    end

    assign slv.awready = grant_wr;
    assign slv.wready  = grant_wr;
    assign slv.arready = grant_rd;

    // ************************************************************************
    // Sequencing
    // ************************************************************************

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= idle;
            last_wr  <= 1'b0;
            bvalid_q <= 1'b0;
            rvalid_q <= 1'b0;
        end else begin
            if (slv.bready) begin
                bvalid_q <= 1'b0;
            end
            if (slv.rready) begin
                rvalid_q <= 1'b0;
            end
            unique case (state)
                idle: begin
                    if (take) begin
                        last_wr <= grant_wr;
                        if (hit) begin
                            state <= setup;
                        end else if (grant_wr) begin
                            bvalid_q <= 1'b1;
                        end else begin
                            rvalid_q <= 1'b1;
                        end
                    end
                end
                setup: begin
                    state <= access;
                end
                access: begin
                    if (sel_pready) begin
                        state <= idle;
                        if (req_write) begin
                            bvalid_q <= 1'b1;
                        end else begin
                            rvalid_q <= 1'b1;
                        end
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            req_addr  <= rebased;
            req_wdata <= slv.wdata;
            req_strb  <= slv.wstrb;
            req_prot  <= grant_wr ? slv.awprot : slv.arprot;
            req_write <= grant_wr;
            req_idx   <= hit_idx;
        end
        // Miss answers without an APB cycle
        if (take && !hit) begin
            bresp_q <= decerr;
            rresp_q <= decerr;
            rdata_q <= '0;
        end
        if (state == access && sel_pready) begin
            bresp_q <= sel_pslverr ? slverr : okay;
            rresp_q <= sel_pslverr ? slverr : okay;
            rdata_q <= sel_prdata;
        end
    end

    // ************************************************************************
    // APB side
    // ************************************************************************

    assign psel0 = (state != idle) && !req_idx;
    assign psel1 = (state != idle) && req_idx;

    assign apb0.psel    = psel0;
    assign apb0.penable = psel0 && (state == access);
    assign apb0.paddr   = req_addr;
    assign apb0.pprot   = req_prot;
    assign apb0.pwrite  = req_write;
    assign apb0.pwdata  = req_wdata;
    assign apb0.pstrb   = req_strb;

    assign apb1.psel    = psel1;
    assign apb1.penable = psel1 && (state == access);
    assign apb1.paddr   = req_addr;
    assign apb1.pprot   = req_prot;
    assign apb1.pwrite  = req_write;
    assign apb1.pwdata  = req_wdata;
    assign apb1.pstrb   = req_strb;

    assign sel_pready  = req_idx ? apb1.pready : apb0.pready;
    assign sel_pslverr = req_idx ? apb1.pslverr : apb0.pslverr;
    assign sel_prdata  = req_idx ? apb1.prdata : apb0.prdata;

    assign slv.bvalid = bvalid_q;
    assign slv.bresp  = bresp_q;
    assign slv.rvalid = rvalid_q;
    assign slv.rresp  = rresp_q;
    assign slv.rdata  = rdata_q;

endmodule

//--- source/apb_regbank.sv
`timescale 1ns/1ps

module apb_regbank import bus_pkg::*; import map_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    apb_if.completer  apb
);

    logic [data_width-1:0] regs [reg_count];
    logic                  xfer;
    logic                  mapped;
    logic [2:0]            idx;

    assign xfer   = apb.psel && apb.penable;
    assign mapped = apb.paddr < reg_count * 4;
    assign idx    = apb.paddr[4:2];

    // Zero wait states
    assign apb.pready  = xfer;
    assign apb.pslverr = xfer && !mapped;
    assign apb.prdata  = mapped ? regs[idx] : '0;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (xfer && apb.pwrite && mapped) begin
            // Only strobed bytes change
            for (int b = 0; b < strb_width; b++) begin
                if (apb.pstrb[b]) begin
                    regs[idx][8*b +: 8] <= apb.pwdata[8*b +: 8];
                end
            end
        end
    end

endmodule

//--- source/periph_top.sv
`timescale 1ns/1ps

module periph_top import bus_pkg::*; (
    input  logic                  clk,
    input  logic                  arst_n,

    input  logic                  awvalid,
    output logic                  awready,
    input  logic [addr_width-1:0] awaddr,
    input  logic [2:0]            awprot,
    input  logic                  wvalid,
    output logic                  wready,
    input  logic [data_width-1:0] wdata,
    input  logic [strb_width-1:0] wstrb,
    output logic                  bvalid,
    input  logic                  bready,
    output resp_e                 bresp,
    input  logic                  arvalid,
    output logic                  arready,
    input  logic [addr_width-1:0] araddr,
    input  logic [2:0]            arprot,
    output logic                  rvalid,
    input  logic                  rready,
    output logic [data_width-1:0] rdata,
    output resp_e                 rresp,

    input  logic                  pause_req,
    output logic                  pause_ack
);

    axil_if top_bus ();
    axil_if brg_bus ();
    apb_if  apb0_bus ();
    apb_if  apb1_bus ();

    // ************************************************************************
    // Plain ports onto the upstream bus
    // ************************************************************************

    assign top_bus.awvalid = awvalid;
    assign top_bus.awaddr  = awaddr;
    assign top_bus.awprot  = awprot;
    assign top_bus.wvalid  = wvalid;
    assign top_bus.wdata   = wdata;
    assign top_bus.wstrb   = wstrb;
    assign top_bus.bready  = bready;
    assign top_bus.arvalid = arvalid;
    assign top_bus.araddr  = araddr;
    assign top_bus.arprot  = arprot;
    assign top_bus.rready  = rready;

    assign awready = top_bus.awready;
    assign wready  = top_bus.wready;
    assign bvalid  = top_bus.bvalid;
    assign bresp   = top_bus.bresp;
    assign arready = top_bus.arready;
    assign rvalid  = top_bus.rvalid;
    assign rdata   = top_bus.rdata;
    assign rresp   = top_bus.rresp;

    // ************************************************************************
    // Pause, bridge and the two banks
    // ************************************************************************

    axil_pause pause_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .pause_req (pause_req),
        .pause_ack (pause_ack),
        .slv       (top_bus.subordinate),
        .mst       (brg_bus.manager)
    );

    axil_apb_bridge bridge_i (
        .clk    (clk),
        .arst_n (arst_n),
        .slv    (brg_bus.subordinate),
        .apb0   (apb0_bus.requester),
        .apb1   (apb1_bus.requester)
    );

    apb_regbank bank0_i (
        .clk    (clk),
        .arst_n (arst_n),
        .apb    (apb0_bus.completer)
    );

    apb_regbank bank1_i (
        .clk    (clk),
        .arst_n (arst_n),
        .apb    (apb1_bus.completer)
    );

endmodule

//--- tests/periph_top_sva.sv
`timescale 1ns/1ps

module periph_top_sva import bus_pkg::*; (
    input logic                  clk,
    input logic                  arst_n,
    input logic                  awvalid,
    input logic                  awready,
    input logic                  arvalid,
    input logic                  arready,
    input logic                  bvalid,
    input logic                  bready,
    input logic [1:0]            bresp,
    input logic                  rvalid,
    input logic                  rready,
    input logic [data_width-1:0] rdata,
    input logic [1:0]            rresp,
    input logic                  pause_ack,
    input logic                  psel0,
    input logic                  penable0,
    input logic                  psel1,
    input logic                  penable1
);

    int failures = 0;

    // ************************************************************************
    // Response channels hold until taken
    // ************************************************************************

    b_stable: assert property (@(posedge clk) disable iff (!arst_n)
        bvalid && !bready |=> bvalid && $stable(bresp))
    else begin
        failures = failures + 1;
        $error("write response dropped or changed before bready");
    end

    r_stable: assert property (@(posedge clk) disable iff (!arst_n)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
    else begin
        failures = failures + 1;
        $error("read response dropped or changed before rready");
    end

    // Nothing new while a response waits
    busy_no_accept: assert property (@(posedge clk) disable iff (!arst_n)
        bvalid || rvalid |-> !awready && !arready)
    else begin
        failures = failures + 1;
        $error("request accepted while a response was pending");
    end

    // ************************************************************************
    // APB sequencing and pause
    // ************************************************************************

    setup_access: assert property (@(posedge clk) disable iff (!arst_n)
        (psel0 && !penable0 |=> psel0 && penable0) and
        (psel1 && !penable1 |=> psel1 && penable1))
    else begin
        failures = failures + 1;
        $error("APB setup phase not followed by access phase");
    end

    pause_quiet: assert property (@(posedge clk) disable iff (!arst_n)
        pause_ack |-> !psel0 && !psel1)
    else begin
        failures = failures + 1;
        $error("APB transfer while pause was acknowledged");
    end

    b_delay: assert property (@(posedge clk) disable iff (!arst_n)
        awvalid && awready |-> ##[1:3] bvalid)
    else begin
        failures = failures + 1;
        $error("write response did not arrive within three cycles");
    end

    r_delay: assert property (@(posedge clk) disable iff (!arst_n)
        arvalid && arready |-> ##[1:3] rvalid)
    else begin
        failures = failures + 1;
        $error("read response did not arrive within three cycles");
    end

endmodule

bind periph_top periph_top_sva sva_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .awvalid   (awvalid),
    .awready   (awready),
    .arvalid   (arvalid),
    .arready   (arready),
    .bvalid    (bvalid),
    .bready    (bready),
    .bresp     (bresp),
    .rvalid    (rvalid),
    .rready    (rready),
    .rdata     (rdata),
    .rresp     (rresp),
    .pause_ack (pause_ack),
    .psel0     (apb0_bus.psel),
    .penable0  (apb0_bus.penable),
    .psel1     (apb1_bus.psel),
    .penable1  (apb1_bus.penable)
);

//--- tests/tb_periph_top.sv
`timescale 1ns/1ps

module tb_periph_top import bus_pkg::*; import map_pkg::*; ();

    localparam int reset_cycles = 16;
    localparam int n_rand       = 16;
    localparam int n_slv        = 4;
    localparam int n_both       = 6;
    localparam int txn_total    = 2 * n_rand + 8 + 2 * n_slv + 2 * reg_count + 2
                                + 2 * n_both + n_both / 2;
    localparam logic [31:0] miss_addr [4] = '{
        32'h0000_0ffc, 32'h0000_1100, 32'h0000_2100, 32'hffff_f000
    };

    logic        clk;
    logic        arst_n;
    logic        awvalid;
    logic        awready;
    logic [31:0] awaddr;
    logic [2:0]  awprot;
    logic        wvalid;
    logic        wready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        bvalid;
    logic        bready;
    resp_e       bresp;
    logic        arvalid;
    logic        arready;
    logic [31:0] araddr;
    logic [2:0]  arprot;
    logic        rvalid;
    logic        rready;
    logic [31:0] rdata;
    resp_e       rresp;
    logic        pause_req;
    logic        pause_ack;

    logic [31:0] rng_state = 32'h25be_a7a6;
    logic [31:0] shadow [periph_count][reg_count];
    bit          miss_active = 1'b0;
    bit          write_done;

    periph_top periph_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ************************************************************************
    // Random source, checking and the bank model
    // ************************************************************************

    function automatic logic [31:0] next_random();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    function automatic logic [31:0] pick_reg_addr();
        logic [31:0] r;
        r = next_random();
        return periph_base[r[3]] + {27'd0, r[2:0], 2'b00};
    endfunction

    task automatic check_equal(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            $display("[ERROR] %s expected %h actual %h", name, exp, act);
            $display("ERRORS FOUND");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic resp_e decode(input logic [31:0] addr, output int bank,
                                     output int idx);
        logic [31:0] off;
        bank = -1;
        idx  = 0;
        off  = '0;
        for (int i = 0; i < periph_count; i++) begin
            if (addr >= periph_base[i] && addr < periph_base[i] + periph_size) begin
                bank = i;
                off  = addr - periph_base[i];
            end
        end
        if (bank < 0) begin
            return decerr;
        end
        idx = int'(off[4:2]);
        if (off < reg_count * 4) begin
            return okay;
        end
        return slverr;
    endfunction

    function automatic resp_e model_write(input logic [31:0] addr, input logic [31:0] data,
                                          input logic [3:0] strb);
        int    bank;
        int    idx;
        resp_e resp;
        resp = decode(addr, bank, idx);
        if (resp == okay) begin
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) begin
                    shadow[bank][idx][8*b +: 8] = data[8*b +: 8];
                end
            end
        end
        return resp;
    endfunction

    function automatic resp_e model_read(input logic [31:0] addr, output logic [31:0] data);
        int    bank;
        int    idx;
        resp_e resp;
        resp = decode(addr, bank, idx);
        data = (resp == okay) ? shadow[bank][idx] : '0;
        return resp;
    endfunction

    // ************************************************************************
    // Bus driver
    // ************************************************************************

    // One write, one read or both at once; responses taken under random stalls
    task automatic run_txn(
        input  bit          do_wr,
        input  bit          do_rd,
        input  logic [31:0] waddr,
        input  logic [31:0] wdat,
        input  logic [3:0]  strb,
        input  logic [31:0] raddr,
        output resp_e       bres,
        output resp_e       rres,
        output logic [31:0] rdat,
        output bit          wr_first
    );
        bit b_pend;
        bit r_pend;
        bit aw_hs;
        bit ar_hs;
        b_pend   = do_wr;
        r_pend   = do_rd;
        bres     = okay;
        rres     = okay;
        rdat     = '0;
        wr_first = 1'b0;
        @(posedge clk);
        awvalid <= do_wr;
        wvalid  <= do_wr;
        awaddr  <= waddr;
        wdata   <= wdat;
        wstrb   <= strb;
        arvalid <= do_rd;
        araddr  <= raddr;
        while (b_pend || r_pend) begin
            @(negedge clk);
            aw_hs = awvalid && awready && wready;
            ar_hs = arvalid && arready;
            // Address and data of a write are taken together
            check_equal("w_with_aw", awvalid && awready, wvalid && wready);
            if (aw_hs && arvalid) begin
                wr_first = 1'b1;
            end
            if (bvalid && bready) begin
                bres   = bresp;
                b_pend = 1'b0;
            end
            if (rvalid && rready) begin
                rres   = rresp;
                rdat   = rdata;
                r_pend = 1'b0;
            end
            @(posedge clk);
            if (aw_hs) begin
                awvalid <= 1'b0;
                wvalid  <= 1'b0;
            end
            if (ar_hs) begin
                arvalid <= 1'b0;
            end
            bready <= (next_random() % 3) != 0;
            rready <= (next_random() % 3) != 0;
        end
        bready <= 1'b0;
        rready <= 1'b0;
    endtask

    task automatic write_check(input string name, input logic [31:0] addr,
                               input logic [31:0] data, input logic [3:0] strb);
        resp_e       exp;
        resp_e       bres;
        resp_e       rres;
        logic [31:0] rdat;
        bit          wf;
        exp = model_write(addr, data, strb);
        run_txn(1'b1, 1'b0, addr, data, strb, '0, bres, rres, rdat, wf);
        check_equal({name, "_bresp"}, exp, bres);
    endtask

    task automatic read_check(input string name, input logic [31:0] addr);
        resp_e       exp;
        resp_e       bres;
        resp_e       rres;
        logic [31:0] exp_data;
        logic [31:0] rdat;
        bit          wf;
        exp = model_read(addr, exp_data);
        run_txn(1'b0, 1'b1, '0, '0, '0, addr, bres, rres, rdat, wf);
        check_equal({name, "_rresp"}, exp, rres);
        check_equal({name, "_rdata"}, exp_data, rdat);
    endtask

    // Decode misses must never select a bank
    always @(negedge clk) begin
        if (miss_active) begin
            check_equal("decode_miss_psel", 0,
                        {periph_top_i.apb1_bus.psel, periph_top_i.apb0_bus.psel});
        end
    end

    initial begin
        wait (periph_top_i.sva_i.failures != 0);
        $display("protocol assertion failed");
        $display("ERRORS FOUND");
        $fatal(1, "protocol assertion failed");
    end

    initial begin
        repeat (reset_cycles + txn_total * 20) @(posedge clk);
        $display("watchdog expired before the tests finished");
        $display("ERRORS FOUND");
        $fatal(1, "timeout");
    end

    // ************************************************************************
    // Test sequence
    // ************************************************************************

    initial begin
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] rnd;
        logic [31:0] rdat;
        logic [31:0] exp_data;
        resp_e       bres;
        resp_e       rres;
        resp_e       exp_w;
        resp_e       exp_r;
        bit          wf;
        int          n_wr_first;
        arst_n    = 1'b0;
        awvalid   = 1'b0;
        awaddr    = '0;
        awprot    = '0;
        wvalid    = 1'b0;
        wdata     = '0;
        wstrb     = '0;
        bready    = 1'b0;
        arvalid   = 1'b0;
        araddr    = '0;
        arprot    = '0;
        rready    = 1'b0;
        pause_req = 1'b0;
        n_wr_first = 0;
        for (int b = 0; b < periph_count; b++) begin
            for (int i = 0; i < reg_count; i++) begin
                shadow[b][i] = '0;
            end
        end
        repeat (reset_cycles) @(posedge clk);
        arst_n <= 1'b1;

        for (int i = 0; i < n_rand; i++) begin
            addr = pick_reg_addr();
            data = next_random();
            rnd  = next_random();
            write_check("rand_write", addr, data, rnd[3:0]);
            read_check("rand_read", pick_reg_addr());
        end

        for (int i = 0; i < 4; i++) begin
            miss_active = 1'b1;
            write_check("miss_write", miss_addr[i], next_random(), 4'hf);
            read_check("miss_read", miss_addr[i]);
            miss_active = 1'b0;
        end

        // Unmapped offsets inside a window
        for (int i = 0; i < n_slv; i++) begin
            rnd  = next_random();
            addr = periph_base[rnd[8]] + 32'h20 + (rnd[7:0] % 56) * 4;
            write_check("slverr_write", addr, next_random(), 4'hf);
            read_check("slverr_read", addr);
        end
        for (int b = 0; b < periph_count; b++) begin
            for (int i = 0; i < reg_count; i++) begin
                read_check("slverr_sweep", periph_base[b] + i * 4);
            end
        end

        addr       = pick_reg_addr();
        rnd        = next_random();
        write_done = 1'b0;
        fork
            begin
                write_check("pause_write", addr, rnd, 4'hf);
                write_done = 1'b1;
            end
            begin
                while (!(awvalid && awready)) @(negedge clk);
                @(posedge clk);
                pause_req <= 1'b1;
                while (!pause_ack) @(negedge clk);
                check_equal("pause_ack_drained", 1, write_done);
            end
        join
        fork
            read_check("pause_read", addr);
            begin
                repeat (8) begin
                    @(negedge clk);
                    check_equal("pause_hold_arready", 0, arready);
                end
                @(posedge clk);
                pause_req <= 1'b0;
            end
        join

        // A lone write first flips the arbiter toward the read
        for (int i = 0; i < n_both; i++) begin
            if (i % 2 == 1) begin
                write_check("both_lead_write", pick_reg_addr(), next_random(), 4'hf);
            end
            addr = pick_reg_addr();
            data = next_random();
            rnd  = next_random();
            run_txn(1'b1, 1'b1, addr, data, rnd[3:0], addr, bres, rres, rdat, wf);
            if (wf) begin
                n_wr_first++;
                exp_w = model_write(addr, data, rnd[3:0]);
                exp_r = model_read(addr, exp_data);
            end else begin
                exp_r = model_read(addr, exp_data);
                exp_w = model_write(addr, data, rnd[3:0]);
            end
            check_equal("both_bresp", exp_w, bres);
            check_equal("both_rresp", exp_r, rres);
            check_equal("both_rdata", exp_data, rdat);
        end
        check_equal("both_orders_seen", 1, n_wr_first > 0 && n_wr_first < n_both);

        repeat (4) @(posedge clk);
        if (periph_top_i.sva_i.failures == 0) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            $display("ERRORS FOUND");
            $fatal(1, "protocol assertion failed");
        end
    end

endmodule

//--- vlog.f
source/bus_pkg.sv
source/map_pkg.sv
source/axil_if.sv
source/apb_if.sv
source/axil_pause.sv
source/axil_apb_bridge.sv
source/apb_regbank.sv
source/periph_top.sv
tests/periph_top_sva.sv
tests/tb_periph_top.sv
